// File: files.f
source/jesd_rx_pkg.sv
source/jesd_sof_tracker.sv
source/jesd_lane_aligner.sv
source/adc_sample_formatter.sv
source/jesd_rx_adc_if.sv
bench/tb_jesd_rx_adc_if.sv

// File: Makefile
# Verilator build and run of the JESD204 rx to ADC interface testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_jesd_rx_adc_if
FILELIST  ?= files.f
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed

# sources come from the file list, so the binary tracks every listed file
SOURCES := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN     := $(MDIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# pass only if the pass message shows up as a line of its own
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -Fqx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

// File: bench/tb_jesd_rx_adc_if.sv
// **************************************************************************
// expected outputs rebuilt from the driven history
// history depth caps the run at 1024 cycles
// **************************************************************************

module tb_jesd_rx_adc_if;

  // cycle budget per test sets the timeout
  localparam int reset_cycles  = 3;
  localparam int idle_cycles   = 6;
  localparam int no_sof_cycles = 20;
  localparam int zero_cycles   = 12;
  localparam int sweep_cycles  = 24;
  localparam int random_cycles = 300;
  localparam int relock_cycles = 24;
  localparam int drain_cycles  = 4;
  localparam int total_cycles  = reset_cycles + idle_cycles + no_sof_cycles + zero_cycles
                                 + sweep_cycles + random_cycles + relock_cycles + drain_cycles;
  localparam int timeout_limit = total_cycles + 50;
  localparam int hist_depth    = 1024;

  logic                                                      rx_clk = 1'b0;
  logic                                                      adc_rst;
  logic [jesd_rx_pkg::sof_width-1:0]                         rx_sof;
  logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] rx_data;
  logic [jesd_rx_pkg::lane_width-1:0]                        adc_data_a;
  logic [jesd_rx_pkg::lane_width-1:0]                        adc_data_b;
  logic                                                      adc_status;

  // name of the test that owns the word on rx_data
  string test_name;

  // what the DUT sampled per rising edge and the tracker model after it
  bit          rst_h    [0:hist_depth-1];
  logic [63:0] word_h   [0:hist_depth-1];
  logic [1:0]  off_h    [0:hist_depth-1];
  bit          locked_h [0:hist_depth-1];
  string       name_h   [0:hist_depth-1];

  int          edge_cnt     = 0;
  int          cycle_cnt    = 0;
  logic [1:0]  model_off    = 2'd0;
  bit          model_locked = 1'b0;

  jesd_rx_adc_if i_dut (
    .rx_clk     (rx_clk),
    .adc_rst    (adc_rst),
    .rx_sof     (rx_sof),
    .rx_data    (rx_data),
    .adc_data_a (adc_data_a),
    .adc_data_b (adc_data_b),
    .adc_status (adc_status)
  );

  // 100 unit period
  always #50 rx_clk = ~rx_clk;

  // **************************************************************************
  // reference model
  // **************************************************************************

  // lowest set marker bit scanned from the top down
  function automatic logic [1:0] lowest_sof(input logic [3:0] sof);
    logic [1:0] idx;
    idx = 2'd0;
    for (int i = 3; i >= 0; i--) begin
      if (sof[i]) begin
        idx = 2'(i);
      end
    end
    return idx;
  endfunction

  // frame window over {current, previous} then an octet swap per sample
  function automatic logic [31:0] format_lane(input logic [31:0] cur, input logic [31:0] prev,
                                              input logic [1:0] off);
    logic [63:0] pair;
    logic [31:0] aligned;
    logic [31:0] swapped;
    int          shift;
    pair = {cur, prev};
    // offset 0 is the current word as it stands
    shift = (off == 2'd0) ? 32 : 8 * int'(off);
    aligned = pair[shift +: 32];
    // octet b of a sample comes from octet b xor 1
    for (int b = 0; b < 4; b++) begin
      swapped[8*b +: 8] = aligned[8*(b ^ 1) +: 8];
    end
    return swapped;
  endfunction

  // expected {status, adc_data_b, adc_data_a} for the word of edge j
  function automatic logic [64:0] reference_output(input int j);
    logic [63:0] cur;
    logic [63:0] prev;
    logic [63:0] lanes;
    logic        status;
    // a word taken in reset reads as zero
    cur = rst_h[j] ? 64'd0 : word_h[j];
    if (rst_h[j] || j == 0) begin
      prev = 64'd0;
    end else begin
      prev = rst_h[j-1] ? 64'd0 : word_h[j-1];
    end
    for (int n = 0; n < jesd_rx_pkg::num_lanes; n++) begin
      lanes[n*32 +: 32] = format_lane(cur[n*32 +: 32], prev[n*32 +: 32], off_h[j]);
    end
    // reset in the two later stages wipes the word on its way out
    status = locked_h[j] && !rst_h[j+1] && !rst_h[j+2];
    if (rst_h[j+1] || rst_h[j+2]) begin
      lanes = 64'd0;
    end
    return {status, lanes};
  endfunction

  task automatic report_failure();
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  // **************************************************************************
  // comparison three edges behind the input
  // **************************************************************************

  always @(posedge rx_clk) begin
    logic [64:0] expected;
    int          j;
    if (edge_cnt >= 3) begin
      j = edge_cnt - 3;
      expected = reference_output(j);
      assert (adc_status === expected[64]) else begin
        $display("ERROR %s: adc_status expected %0b actual %0b",
                 name_h[j], expected[64], adc_status);
        report_failure();
      end
      // data only counts once locked and in the idle phase
      if (expected[64] || name_h[j] == "reset_idle") begin
        assert (adc_data_a === expected[31:0]) else begin
          $display("ERROR %s: adc_data_a expected %h actual %h",
                   name_h[j], expected[31:0], adc_data_a);
          report_failure();
        end
        assert (adc_data_b === expected[63:32]) else begin
          $display("ERROR %s: adc_data_b expected %h actual %h",
                   name_h[j], expected[63:32], adc_data_b);
          report_failure();
        end
      end
    end
    // tracker model where a marker applies to its own word
    if (adc_rst) begin
      model_off    = 2'd0;
      model_locked = 1'b0;
    end else if (rx_sof != 4'b0000) begin
      model_off    = lowest_sof(rx_sof);
      model_locked = 1'b1;
    end
    rst_h[edge_cnt]    = adc_rst;
    word_h[edge_cnt]   = rx_data;
    off_h[edge_cnt]    = model_off;
    locked_h[edge_cnt] = model_locked;
    name_h[edge_cnt]   = test_name;
    edge_cnt++;
  end

  // run length guard
  always @(posedge rx_clk) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("timeout: the run went past %0d cycles without finishing", timeout_limit);
      report_failure();
    end
  end

  // **************************************************************************
  // stimulus on the falling edge
  // **************************************************************************

  task automatic drive_word(input string name, input logic rst, input logic [3:0] sof,
                            input logic [63:0] data);
    @(negedge rx_clk);
    test_name = name;
    adc_rst   = rst;
    rx_sof    = sof;
    rx_data   = data;
  endtask

  function automatic logic [63:0] random_word();
    return {$urandom, $urandom};
  endfunction

  // single and multi-bit markers that move the offset every time
  function automatic logic [3:0] sweep_marker(input int idx);
    case (idx)
      0: return 4'b0010;
      1: return 4'b1100;
      2: return 4'b1000;
      3: return 4'b0111;
      4: return 4'b0100;
      default: return 4'b1010;
    endcase
  endfunction

  initial begin
    logic [3:0] sof;
    adc_rst   = 1'b1;
    rx_sof    = 4'b0000;
    rx_data   = 64'd0;
    test_name = "reset_idle";
    void'($urandom(28));
    repeat (reset_cycles) @(negedge rx_clk);
    adc_rst = 1'b0;
    // quiet link after reset
    repeat (idle_cycles - 1) drive_word("reset_idle", 1'b0, 4'b0000, 64'd0);
    // traffic without any marker
    repeat (no_sof_cycles) drive_word("no_sof", 1'b0, 4'b0000, random_word());
    // frame start on byte 0
    drive_word("offset_zero", 1'b0, 4'b0001, random_word());
    repeat (zero_cycles - 1) drive_word("offset_zero", 1'b0, 4'b0000, random_word());
    // each marker followed by three plain words
    for (int i = 0; i < 6; i++) begin
      drive_word("offset_sweep", 1'b0, sweep_marker(i), random_word());
      repeat (3) drive_word("offset_sweep", 1'b0, 4'b0000, random_word());
    end
    // marker on about one word in 16
    for (int i = 0; i < random_cycles; i++) begin
      sof = ($urandom % 16 == 0) ? 4'($urandom % 15 + 1) : 4'b0000;
      drive_word("random_stream", 1'b0, sof, random_word());
    end
    // reset mid-stream where a marker under reset is ignored
    repeat (4) drive_word("reset_relock", 1'b0, 4'b0000, random_word());
    drive_word("reset_relock", 1'b1, 4'b0000, random_word());
    drive_word("reset_relock", 1'b1, 4'b0100, random_word());
    drive_word("reset_relock", 1'b1, 4'b0000, random_word());
    repeat (6) drive_word("reset_relock", 1'b0, 4'b0000, random_word());
    drive_word("reset_relock", 1'b0, 4'b1010, random_word());
    repeat (10) drive_word("reset_relock", 1'b0, 4'b0000, random_word());
    // let the pipeline empty into the checker
    repeat (drain_cycles) @(negedge rx_clk);
    $display("All tests passed");
    $finish;
  end

endmodule

// File: source/jesd_rx_adc_if.sv
// **************************************************************************
// JESD204 rx to dual-channel ADC data path, three rx_clk stages in total
// no back-pressure, no over-range flags, the link layer is assumed deskewed
// **************************************************************************

module jesd_rx_adc_if (
  // rx_clk is the link word clock
  input  logic                                              rx_clk,
  input  logic                                              adc_rst,
  // link layer side, lane n in bits 32n+31 to 32n
  input  logic [jesd_rx_pkg::sof_width-1:0]                 rx_sof,
  input  logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] rx_data,
  // ADC data path side
  output logic [jesd_rx_pkg::lane_width-1:0]                adc_data_a,
  output logic [jesd_rx_pkg::lane_width-1:0]                adc_data_b,
  output logic                                              adc_status
);

  // tracker to aligners
  logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] lane_data;
  logic [jesd_rx_pkg::offset_width-1:0]                      frame_offset;
  jesd_rx_pkg::tracker_state_t                               track_state;

  // aligners to formatter, lane n in the same slice as on rx_data
  logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] aligned;

  // **************************************************************************
  // frame start tracking
  // **************************************************************************

  jesd_sof_tracker i_sof_tracker (
    .rx_clk       (rx_clk),
    .adc_rst      (adc_rst),
    .rx_sof       (rx_sof),
    .rx_data      (rx_data),
    .lane_data    (lane_data),
    .frame_offset (frame_offset),
    .track_state  (track_state)
  );

  // **************************************************************************
  // per-lane alignment
  // **************************************************************************

  // both lanes share one offset
  for (genvar n = 0; n < jesd_rx_pkg::num_lanes; n++) begin : g_lane
    jesd_lane_aligner i_lane_aligner (
      .rx_clk       (rx_clk),
      .adc_rst      (adc_rst),
      .lane_word    (lane_data[n*jesd_rx_pkg::lane_width +: jesd_rx_pkg::lane_width]),
      .frame_offset (frame_offset),
      .aligned_word (aligned[n*jesd_rx_pkg::lane_width +: jesd_rx_pkg::lane_width])
    );
  end

  // sample order and status
  adc_sample_formatter i_sample_formatter (
    .rx_clk      (rx_clk),
    .adc_rst     (adc_rst),
    .aligned_a   (aligned[0 +: jesd_rx_pkg::lane_width]),
    .aligned_b   (aligned[jesd_rx_pkg::lane_width +: jesd_rx_pkg::lane_width]),
    .track_state (track_state),
    .adc_data_a  (adc_data_a),
    .adc_data_b  (adc_data_b),
    .adc_status  (adc_status)
  );

endmodule

// File: source/adc_sample_formatter.sv
// **************************************************************************
// byte-swaps both aligned lanes into two 16-bit samples per channel
// status follows the tracker lock, delayed to match the aligner stage
// **************************************************************************

module adc_sample_formatter (
  input  logic                                rx_clk,
  input  logic                                adc_rst,
  // aligned lanes, lane 0 is channel a
  input  logic [jesd_rx_pkg::lane_width-1:0]  aligned_a,
  input  logic [jesd_rx_pkg::lane_width-1:0]  aligned_b,
  // tracker state, one stage ahead of the aligned lanes
  input  jesd_rx_pkg::tracker_state_t         track_state,
  // ADC data path side
  output logic [jesd_rx_pkg::lane_width-1:0]  adc_data_a,
  output logic [jesd_rx_pkg::lane_width-1:0]  adc_data_b,
  output logic                                adc_status
);

  // tracker state lined up with aligner output
  jesd_rx_pkg::tracker_state_t state_d;

  // swapped samples, high and low half of each channel
  logic [jesd_rx_pkg::sample_width-1:0] samp_a_hi;
  logic [jesd_rx_pkg::sample_width-1:0] samp_a_lo;
  logic [jesd_rx_pkg::sample_width-1:0] samp_b_hi;
  logic [jesd_rx_pkg::sample_width-1:0] samp_b_lo;

  // **************************************************************************
  // byte order
  // **************************************************************************

  // octets arrive msb first on the link
  // so swap the two bytes inside each sample
  assign samp_a_hi = {aligned_a[23:16], aligned_a[31:24]};
  assign samp_a_lo = {aligned_a[7:0], aligned_a[15:8]};
  assign samp_b_hi = {aligned_b[23:16], aligned_b[31:24]};
  assign samp_b_lo = {aligned_b[7:0], aligned_b[15:8]};

  // **************************************************************************
  // output registers
  // **************************************************************************

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      state_d    <= jesd_rx_pkg::st_search;
      adc_data_a <= '0;
      adc_data_b <= '0;
      adc_status <= 1'b0;
    end else begin
      // one stage for the aligner
      state_d    <= track_state;
      adc_data_a <= {samp_a_hi, samp_a_lo};
      adc_data_b <= {samp_b_hi, samp_b_lo};
      // status goes high with the first aligned samples
      adc_status <= (state_d == jesd_rx_pkg::st_locked);
    end
  end

endmodule

// File: source/jesd_lane_aligner.sv
// **************************************************************************
// realigns one lane to the frame boundary from the current and previous word
// offset must arrive in the same cycle as the word it belongs to
// **************************************************************************

module jesd_lane_aligner (
  input  logic                                  rx_clk,
  input  logic                                  adc_rst,
  // one lane slice from the tracker
  input  logic [jesd_rx_pkg::lane_width-1:0]    lane_word,
  input  logic [jesd_rx_pkg::offset_width-1:0]  frame_offset,
  // realigned lane, registered
  output logic [jesd_rx_pkg::lane_width-1:0]    aligned_word
);

  // lane word of the previous cycle
  logic [jesd_rx_pkg::lane_width-1:0] prev_word;
  // byte window picked by the offset
  logic [jesd_rx_pkg::lane_width-1:0] window;

  // **************************************************************************
  // byte window select
  // **************************************************************************

  // frame start at byte n of the word: the upper octets of the previous
  // word come first and the low octets of the current word complete it
  always_comb begin
    case (frame_offset)
      2'd1: begin
        window = {lane_word[7:0], prev_word[31:8]};
      end
      2'd2: begin
        window = {lane_word[15:0], prev_word[31:16]};
      end
      2'd3: begin
        window = {lane_word[23:0], prev_word[31:24]};
      end
      default: begin
        // frame starts on byte 0, word already aligned
        window = lane_word;
      end
    endcase
  end

  // **************************************************************************
  // history and output registers
  // **************************************************************************

  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      prev_word    <= '0;
      aligned_word <= '0;
    end else begin
      // stream never stalls, so history shifts every cycle
      prev_word    <= lane_word;
      aligned_word <= window;
    end
  end

endmodule

// File: source/jesd_sof_tracker.sv
// **************************************************************************
// registers the link word and latches the frame start offset
// the lowest marker bit wins when several are set, lock is cleared by reset
// **************************************************************************

module jesd_sof_tracker (
  input  logic                                              rx_clk,
  input  logic                                              adc_rst,
  // link layer side
  input  logic [jesd_rx_pkg::sof_width-1:0]                 rx_sof,
  input  logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] rx_data,
  // to the lane aligners, all three in step
  output logic [jesd_rx_pkg::num_lanes*jesd_rx_pkg::lane_width-1:0] lane_data,
  output logic [jesd_rx_pkg::offset_width-1:0]              frame_offset,
  output jesd_rx_pkg::tracker_state_t                       track_state
);

  // index of the lowest asserted marker bit
  logic [jesd_rx_pkg::offset_width-1:0] sof_idx;
  // any marker bit set this cycle
  logic                                 sof_hit;

  // **************************************************************************
  // marker decode
  // **************************************************************************

  assign sof_hit = |rx_sof;

  // priority encoder, bit 0 first
  always_comb begin
    if (rx_sof[0]) begin
      sof_idx = 2'd0;
    end else if (rx_sof[1]) begin
      sof_idx = 2'd1;
    end else if (rx_sof[2]) begin
      sof_idx = 2'd2;
    end else begin
      // bit 3, or no marker at all (then unused)
      sof_idx = 2'd3;
    end
  end

  // **************************************************************************
  // word, offset and lock registers
  // **************************************************************************

  // word and its offset leave on the same edge
  // so a marker applies to the very word it came with
  always_ff @(posedge rx_clk) begin
    if (adc_rst) begin
      lane_data    <= '0;
      frame_offset <= '0;
      track_state  <= jesd_rx_pkg::st_search;
    end else begin
      lane_data <= rx_data;
      if (sof_hit) begin
        frame_offset <= sof_idx;
        track_state  <= jesd_rx_pkg::st_locked;
      end
      // no marker: offset and state hold
    end
  end

endmodule

// File: source/jesd_rx_pkg.sv
// **************************************************************************
// shared widths and tracker state for the JESD204 rx to ADC data path
// two lanes and two channels only, one 64-bit word per rx_clk
// **************************************************************************

package jesd_rx_pkg;

  // lanes in, and ADC channels out
  localparam int num_lanes = 2;

  // one lane word per rx_clk, four octets
  localparam int lane_width = 32;

  // start-of-frame marker, one bit per byte position
  localparam int sof_width = 4;

  // byte offset of the frame start inside a lane word
  localparam int offset_width = 2;

  // one ADC sample, two octets
  localparam int sample_width = 16;

  // frame tracker state
  // search until the first marker is seen, then locked until reset
  typedef enum logic [0:0] {
    st_search = 1'b0,
    st_locked = 1'b1
  } tracker_state_t;

endpackage
